// File: flist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/btb_pkg.sv
rtl/btb_way.sv
rtl/btb_plru.sv
rtl/btb_hit_select.sv
rtl/btb.sv
test/btb_properties.sv
test/btb_tb.sv

// File: rtl/btb.sv
/* branch target buffer top: index and tag hashing, write routing,
   two lookup ways, PLRU replacement and hit selection */

`include "btb_macros.svh"

module btb (
    input  logic                   CLK,
    input  logic                   rst,

    input  fetch_pkg::asid_t       arch_asid,

    // read request
    input  logic                   read_req_valid,
    input  fetch_pkg::fetch_idx_t  read_req_fetch_index,

    // read response, one cycle later
    input  fetch_pkg::pc38_t       read_resp_pc38,
    output logic                   read_resp_hit,
    output btb_pkg::btb_way_idx_t  read_resp_hit_way,
    output fetch_pkg::fetch_lane_t read_resp_hit_lane,
    output logic                   read_resp_double_hit,
    output btb_pkg::btb_info_t     read_resp_btb_info,

    // update
    input  logic                   update_valid,
    input  fetch_pkg::pc38_t       update_pc38,
    input  btb_pkg::btb_info_t     update_btb_info,
    input  logic                   update_hit,
    input  btb_pkg::btb_way_idx_t  update_hit_way
);

    import btb_pkg::*;
    import fetch_pkg::*;

    // ------------------------------------------------------------------
    // hashing and write routing

    btb_idx_t             read_index;
    btb_idx_t             update_index;
    btb_tag_t             resp_tag;
    fetch_lane_t          resp_lane;
    btb_entry_t           write_entry;
    btb_way_idx_t         victim_way;
    btb_way_idx_t         write_way;
    logic [`BTB_ASSOC-1:0] way_write_en;

    btb_way_result_t      way0_result;
    btb_way_result_t      way1_result;

    always_comb begin
        read_index   = btb_index_hash(read_req_fetch_index, arch_asid);
        resp_tag     = btb_tag_hash(read_resp_pc38, arch_asid);
        resp_lane    = fetch_lane_bits(read_resp_pc38);

        update_index = btb_index_hash(fetch_idx_bits(update_pc38), arch_asid);

        write_entry.tag  = btb_tag_hash(update_pc38, arch_asid);
        write_entry.lane = fetch_lane_bits(update_pc38);
        write_entry.info = update_btb_info;

        // overwrite the hit way, else allocate the PLRU victim
        write_way = update_hit ? update_hit_way : victim_way;

        way_write_en = '0;
        if (update_valid) begin
            way_write_en[write_way] = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // ways, replacement, selection

    btb_way u_way0 (
        .CLK         (CLK),
        .rst         (rst),
        .read_valid  (read_req_valid),
        .read_index  (read_index),
        .resp_tag    (resp_tag),
        .resp_lane   (resp_lane),
        .write_en    (way_write_en[0]),
        .write_index (update_index),
        .write_entry (write_entry),
        .result      (way0_result)
    );

    btb_way u_way1 (
        .CLK         (CLK),
        .rst         (rst),
        .read_valid  (read_req_valid),
        .read_index  (read_index),
        .resp_tag    (resp_tag),
        .resp_lane   (resp_lane),
        .write_en    (way_write_en[1]),
        .write_index (update_index),
        .write_entry (write_entry),
        .result      (way1_result)
    );

    btb_plru u_plru (
        .CLK            (CLK),
        .rst            (rst),
        .update_valid   (update_valid),
        .update_index   (update_index),
        .update_hit     (update_hit),
        .update_hit_way (update_hit_way),
        .victim_way     (victim_way)
    );

    btb_hit_select u_hit_select (
        .way0       (way0_result),
        .way1       (way1_result),
        .hit        (read_resp_hit),
        .double_hit (read_resp_double_hit),
        .hit_way    (read_resp_hit_way),
        .hit_lane   (read_resp_hit_lane),
        .info       (read_resp_btb_info)
    );

endmodule

// File: rtl/btb_hit_select.sv
/* merges the two way lookups into one buffer response */

module btb_hit_select (
    input  btb_pkg::btb_way_result_t way0,
    input  btb_pkg::btb_way_result_t way1,

    output logic                     hit,
    output logic                     double_hit,
    output btb_pkg::btb_way_idx_t    hit_way,
    output fetch_pkg::fetch_lane_t   hit_lane,
    output btb_pkg::btb_info_t       info
);

    // way 1 wins alone, or on a double hit with lower or equal lane
    logic pick_way1;

    always_comb begin
        hit        = way0.hit | way1.hit;
        double_hit = way0.hit & way1.hit;

        pick_way1  = way1.hit & (~way0.hit | (way1.lane <= way0.lane));

        if (pick_way1) begin
            hit_way  = 1'b1;
            hit_lane = way1.lane;
            info     = way1.info;
        end

        // way 0 hit, or no hit at all
        else begin
            hit_way  = 1'b0;
            hit_lane = way0.lane;
            info     = way0.info;
        end
    end

endmodule

// File: rtl/btb_macros.svh
/* sizes and field widths of the branch target buffer and the fetch block */

`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

// buffer geometry
`define BTB_SETS 64
`define LOG_BTB_SETS 6
`define BTB_ASSOC 2

// fetch block shape, 8 instructions per block
`define FETCH_LANES 8
`define LOG_FETCH_LANES 3

// field widths
`define PC_WIDTH 38
`define ASID_WIDTH 9
`define BTB_ACTION_WIDTH 3
`define BTB_TARGET_WIDTH 32

`endif

// File: rtl/btb_pkg.sv
/* buffer entry, index, tag and way result types plus index and tag hashes */

`include "btb_macros.svh"

package btb_pkg;

    // tag covers the PC bits above index and lane
    localparam int BTB_TAG_WIDTH = `PC_WIDTH - `LOG_BTB_SETS - `LOG_FETCH_LANES;

    typedef logic [`LOG_BTB_SETS-1:0]       btb_idx_t;
    typedef logic [BTB_TAG_WIDTH-1:0]       btb_tag_t;
    typedef logic [$clog2(`BTB_ASSOC)-1:0]  btb_way_idx_t;

    // action of zero means no branch in this slot
    typedef struct packed {
        logic [`BTB_ACTION_WIDTH-1:0] action;
        logic [`BTB_TARGET_WIDTH-1:0] target;
    } btb_info_t;

    typedef struct packed {
        btb_tag_t               tag;
        fetch_pkg::fetch_lane_t lane;
        btb_info_t              info;
    } btb_entry_t;

    // lookup outcome of a single way
    typedef struct packed {
        logic                   hit;
        fetch_pkg::fetch_lane_t lane;
        btb_info_t              info;
    } btb_way_result_t;

    // ------------------------------------------------------------------
    // hashes

    function automatic btb_idx_t btb_index_hash(fetch_pkg::fetch_idx_t idx,
                                                fetch_pkg::asid_t asid);
        return idx ^ asid[`LOG_BTB_SETS-1:0];
    endfunction

    function automatic btb_tag_t btb_tag_hash(fetch_pkg::pc38_t pc, fetch_pkg::asid_t asid);
        return pc[`PC_WIDTH-1 : `LOG_BTB_SETS + `LOG_FETCH_LANES] ^ btb_tag_t'(asid);
    endfunction

endpackage

// File: rtl/btb_plru.sv
/* per-set PLRU bits with victim lookup and update on write */

`include "btb_macros.svh"

module btb_plru (
    input  logic                  CLK,
    input  logic                  rst,

    input  logic                  update_valid,
    input  btb_pkg::btb_idx_t     update_index,
    input  logic                  update_hit,
    input  btb_pkg::btb_way_idx_t update_hit_way,

    output btb_pkg::btb_way_idx_t victim_way
);

    import btb_pkg::*;

    // one bit per set, names the way to replace next
    logic [`BTB_SETS-1:0] plru_bits;

    btb_way_idx_t         written_way;

    always_comb begin
        victim_way = btb_way_idx_t'(plru_bits[update_index]);
        if (update_hit) begin
            written_way = update_hit_way;
        end else begin
            written_way = victim_way;
        end
    end

    // point away from the way just written
    always_ff @(posedge CLK) begin
        if (rst) begin
            plru_bits <= '0;
        end else if (update_valid) begin
            plru_bits[update_index] <= ~written_way;
        end
    end

endmodule

// File: rtl/btb_way.sv
/* one buffer way: entry array, valid flops, registered read, hit compare */

`include "btb_macros.svh"

module btb_way (
    input  logic                      CLK,
    input  logic                      rst,

    // read request, indexed by hashed set
    input  logic                      read_valid,
    input  btb_pkg::btb_idx_t         read_index,

    // response compare inputs
    input  btb_pkg::btb_tag_t         resp_tag,
    input  fetch_pkg::fetch_lane_t    resp_lane,

    // write port
    input  logic                      write_en,
    input  btb_pkg::btb_idx_t         write_index,
    input  btb_pkg::btb_entry_t       write_entry,

    output btb_pkg::btb_way_result_t  result
);

    import btb_pkg::*;

    // ------------------------------------------------------------------
    // storage

    btb_entry_t           entry_array [`BTB_SETS];
    logic [`BTB_SETS-1:0] valid_array;

    // registered read data
    btb_entry_t           rd_entry;
    logic                 rd_valid;

    // read-first, a same-set write lands after the read samples
    always_ff @(posedge CLK) begin
        if (read_valid) begin
            rd_entry <= entry_array[read_index];
        end
        if (write_en) begin
            entry_array[write_index] <= write_entry;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            valid_array <= '0;
            rd_valid    <= 1'b0;
        end else begin
            if (write_en) begin
                valid_array[write_index] <= 1'b1;
            end
            if (read_valid) begin
                rd_valid <= valid_array[read_index];
            end
        end
    end

    // ------------------------------------------------------------------
    // hit compare

    // valid, real branch, tag match, branch at or past fetch lane
    always_comb begin
        result.hit  = rd_valid
                    & (rd_entry.info.action != '0)
                    & (rd_entry.tag == resp_tag)
                    & (rd_entry.lane >= resp_lane);
        result.lane = rd_entry.lane;
        result.info = rd_entry.info;
    end

endmodule

// File: rtl/fetch_pkg.sv
/* fetch address, lane and ASID types with PC field extraction */

`include "btb_macros.svh"

package fetch_pkg;

    // ------------------------------------------------------------------
    // fetch address fields

    typedef logic [`PC_WIDTH-1:0] pc38_t;

    // fetch block index sits just above the lane bits
    typedef logic [`LOG_BTB_SETS-1:0] fetch_idx_t;

    typedef logic [$clog2(`FETCH_LANES)-1:0] fetch_lane_t;

    typedef logic [`ASID_WIDTH-1:0] asid_t;

    // ------------------------------------------------------------------
    // field extraction

    function automatic fetch_lane_t fetch_lane_bits(pc38_t pc);
        return pc[`LOG_FETCH_LANES-1:0];
    endfunction

    function automatic fetch_idx_t fetch_idx_bits(pc38_t pc);
        return pc[`LOG_FETCH_LANES +: `LOG_BTB_SETS];
    endfunction

endpackage

// File: test/btb_properties.sv
/* bound checker: shadow copy of the buffer, expected response and
   assertions on responses and replacement */

`include "btb_macros.svh"

module btb_properties (
    input  logic                   CLK,
    input  logic                   rst,
    input  fetch_pkg::asid_t       arch_asid,
    input  logic                   read_req_valid,
    input  fetch_pkg::fetch_idx_t  read_req_fetch_index,
    input  fetch_pkg::pc38_t       read_resp_pc38,
    input  logic                   read_resp_hit,
    input  btb_pkg::btb_way_idx_t  read_resp_hit_way,
    input  fetch_pkg::fetch_lane_t read_resp_hit_lane,
    input  logic                   read_resp_double_hit,
    input  btb_pkg::btb_info_t     read_resp_btb_info,
    input  logic                   update_valid,
    input  fetch_pkg::pc38_t       update_pc38,
    input  btb_pkg::btb_info_t     update_btb_info,
    input  logic                   update_hit,
    input  btb_pkg::btb_way_idx_t  update_hit_way,
    input  btb_pkg::btb_way_idx_t  write_way
);

    import btb_pkg::*;
    import fetch_pkg::*;

    int fail_count = 0;

    // shadow table with one entry array and valid vector per way
    btb_entry_t            sh_entry [`BTB_ASSOC][`BTB_SETS];
    logic [`BTB_SETS-1:0]  sh_valid [`BTB_ASSOC];
    logic [`BTB_SETS-1:0]  sh_plru;
    logic                  any_update;

    // set contents captured at the request edge
    btb_entry_t            snap_entry [`BTB_ASSOC];
    logic [`BTB_ASSOC-1:0] snap_valid;
    logic                  resp_pending;

    btb_idx_t              rd_set;
    btb_idx_t              upd_set;
    btb_way_idx_t          upd_way;
    btb_entry_t            upd_entry;
    btb_tag_t              resp_tag;
    fetch_lane_t           resp_lane;
    logic [`BTB_ASSOC-1:0] way_hit;
    logic                  exp_hit;
    logic                  exp_double;
    btb_way_idx_t          exp_way;

    // ------------------------------------------------------------------
    // expected values from the lookup rules

    always_comb begin
        rd_set    = read_req_fetch_index ^ arch_asid[5:0];
        upd_set   = update_pc38[8:3] ^ arch_asid[5:0];
        upd_way   = update_hit ? update_hit_way : btb_way_idx_t'(sh_plru[upd_set]);
        upd_entry.tag  = update_pc38[37:9] ^ btb_tag_t'(arch_asid);
        upd_entry.lane = update_pc38[2:0];
        upd_entry.info = update_btb_info;

        resp_tag  = read_resp_pc38[37:9] ^ btb_tag_t'(arch_asid);
        resp_lane = read_resp_pc38[2:0];
        way_hit[0] = snap_valid[0] && (snap_entry[0].info.action != 0)
                   && (snap_entry[0].tag == resp_tag) && (snap_entry[0].lane >= resp_lane);
        way_hit[1] = snap_valid[1] && (snap_entry[1].info.action != 0)
                   && (snap_entry[1].tag == resp_tag) && (snap_entry[1].lane >= resp_lane);

        exp_hit    = way_hit[0] | way_hit[1];
        exp_double = way_hit[0] & way_hit[1];
        // lower lane wins, way 1 on equal lanes
        exp_way    = way_hit[1] && (!way_hit[0] || snap_entry[1].lane <= snap_entry[0].lane);
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            sh_valid[0]  <= '0;
            sh_valid[1]  <= '0;
            sh_plru      <= '0;
            any_update   <= 1'b0;
            snap_valid   <= '0;
            resp_pending <= 1'b0;
        end else begin
            resp_pending <= read_req_valid;
            if (read_req_valid) begin
                snap_valid[0] <= sh_valid[0][rd_set];
                snap_valid[1] <= sh_valid[1][rd_set];
                snap_entry[0] <= sh_entry[0][rd_set];
                snap_entry[1] <= sh_entry[1][rd_set];
            end
            if (update_valid) begin
                sh_entry[upd_way][upd_set] <= upd_entry;
                sh_valid[upd_way][upd_set] <= 1'b1;
                sh_plru[upd_set]           <= ~upd_way;
                any_update                 <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // assertions

    a_no_early_hit: assert property (@(posedge CLK) disable iff (rst)
        resp_pending && !any_update |-> !read_resp_hit)
    else begin
        $error("** Error read_resp_hit: got %h expected 0 before the first update",
               $sampled(read_resp_hit));
        fail_count++;
    end

    a_resp_flags: assert property (@(posedge CLK) disable iff (rst)
        resp_pending |-> (read_resp_hit == exp_hit) && (read_resp_double_hit == exp_double))
    else begin
        $error("** Error read_resp_hit/read_resp_double_hit: got %h/%h expected %h/%h",
               $sampled(read_resp_hit), $sampled(read_resp_double_hit),
               $sampled(exp_hit), $sampled(exp_double));
        fail_count++;
    end

    a_resp_data: assert property (@(posedge CLK) disable iff (rst)
        resp_pending && (exp_hit || snap_valid[0]) |->
            {read_resp_hit_way, read_resp_hit_lane, read_resp_btb_info}
            == {exp_way, snap_entry[exp_way].lane, snap_entry[exp_way].info})
    else begin
        $error("** Error read_resp_hit_way/lane/btb_info: got %h/%h/%h expected %h/%h/%h",
               $sampled(read_resp_hit_way), $sampled(read_resp_hit_lane),
               $sampled(read_resp_btb_info), $sampled(exp_way),
               $sampled(snap_entry[exp_way].lane), $sampled(snap_entry[exp_way].info));
        fail_count++;
    end

    a_victim_way: assert property (@(posedge CLK) disable iff (rst)
        update_valid && !update_hit |-> write_way == sh_plru[upd_set])
    else begin
        $error("** Error write_way: got %h expected %h",
               $sampled(write_way), $sampled(sh_plru[upd_set]));
        fail_count++;
    end

endmodule

bind btb btb_properties u_props (.*);

// File: test/btb_tb.sv
/* testbench for the branch target buffer: clock, reset and directed
   sequences with random tags and info */

module btb_tb;

    import btb_pkg::*;
    import fetch_pkg::*;

    logic         CLK = 1'b0;
    logic         rst;
    asid_t        arch_asid;
    logic         read_req_valid;
    fetch_idx_t   read_req_fetch_index;
    pc38_t        read_resp_pc38;
    logic         read_resp_hit;
    btb_way_idx_t read_resp_hit_way;
    fetch_lane_t  read_resp_hit_lane;
    logic         read_resp_double_hit;
    btb_info_t    read_resp_btb_info;
    logic         update_valid;
    pc38_t        update_pc38;
    btb_info_t    update_btb_info;
    logic         update_hit;
    btb_way_idx_t update_hit_way;

    int    seed = 32'hdeba;
    int    test_num = 0;
    int    errs_before = 0;
    int    wait_cnt;
    bit    timed_out = 1'b0;
    pc38_t pc_a;
    pc38_t pc_b;
    pc38_t pc_c;

    always #50 CLK = ~CLK;

    btb i_btb (.*);

    // ------------------------------------------------------------------
    // stimulus helpers

    function automatic pc38_t rand_pc(input fetch_idx_t idx, input fetch_lane_t lane);
        return {29'($random(seed)), idx, lane};
    endfunction

    // action never zero, so the entry is a real branch
    function automatic btb_info_t rand_info();
        btb_info_t info;
        info.action = 3'(({$random(seed)} % 7) + 1);
        info.target = $random(seed);
        return info;
    endfunction

    // request cycle, then response cycle with the full PC
    task automatic lookup(input pc38_t pc);
        @(posedge CLK);
        read_req_valid       <= 1'b1;
        read_req_fetch_index <= pc[8:3];
        @(posedge CLK);
        read_req_valid <= 1'b0;
        read_resp_pc38 <= pc;
        @(posedge CLK);
    endtask

    task automatic update(input pc38_t pc, input btb_info_t info,
                          input logic hit, input btb_way_idx_t way);
        @(posedge CLK);
        update_valid    <= 1'b1;
        update_pc38     <= pc;
        update_btb_info <= info;
        update_hit      <= hit;
        update_hit_way  <= way;
        @(posedge CLK);
        update_valid <= 1'b0;
    endtask

    task automatic set_asid(input asid_t asid);
        @(posedge CLK);
        arch_asid <= asid;
    endtask

    // let pending responses get checked, then print the test line
    task automatic report(input string name);
        wait_cnt = 0;
        do begin
            @(negedge CLK);
            wait_cnt++;
        end while (i_btb.u_props.resp_pending && wait_cnt < 8);
        test_num++;
        if (i_btb.u_props.resp_pending) begin
            $display("timeout: read response still pending after %s", name);
            timed_out = 1'b1;
        end else begin
            $display("test %0d %s: %0d assertion errors", test_num, name,
                     i_btb.u_props.fail_count - errs_before);
        end
        errs_before = i_btb.u_props.fail_count;
    endtask

    // ------------------------------------------------------------------
    // sequences

    initial begin
        rst                  = 1'b1;
        arch_asid            = '0;
        read_req_valid       = 1'b0;
        read_req_fetch_index = '0;
        read_resp_pc38       = '0;
        update_valid         = 1'b0;
        update_pc38          = '0;
        update_btb_info      = '0;
        update_hit           = 1'b0;
        update_hit_way       = '0;

        repeat (16) @(posedge CLK);
        rst <= 1'b0;
        wait_cnt = 0;
        while (i_btb.rst !== 1'b0 && wait_cnt < 4) begin
            @(posedge CLK);
            wait_cnt++;
        end
        if (i_btb.rst !== 1'b0) begin
            $display("timeout: reset was not released");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            repeat (8) lookup(rand_pc(6'($random(seed)), 3'($random(seed))));
            report("reads after reset");

            pc_a = rand_pc(6'd5, 3'd3);
            update(pc_a, rand_info(), 1'b0, 1'b0);
            lookup(pc_a);
            lookup({pc_a[37:3], 3'd1});
            lookup({pc_a[37:3], 3'd5});
            report("write then read");

            // three allocations in one set walk the PLRU bit
            pc_a = rand_pc(6'd12, 3'd2);
            pc_b = rand_pc(6'd12, 3'd2);
            pc_c = rand_pc(6'd12, 3'd2);
            update(pc_a, rand_info(), 1'b0, 1'b0);
            update(pc_b, rand_info(), 1'b0, 1'b0);
            update(pc_c, rand_info(), 1'b0, 1'b0);
            lookup(pc_a);
            lookup(pc_b);
            lookup(pc_c);
            report("replacement");

            pc_a = rand_pc(6'd20, 3'd2);
            update(pc_a, rand_info(), 1'b0, 1'b0);
            update({pc_a[37:3], 3'd6}, rand_info(), 1'b0, 1'b0);
            lookup({pc_a[37:3], 3'd0});
            // way 1 rewritten to the same lane as way 0
            update(pc_a, rand_info(), 1'b1, 1'b1);
            lookup({pc_a[37:3], 3'd0});
            report("double hit");

            pc_a = rand_pc(6'd33, 3'd4);
            pc_b = rand_pc(6'd33, 3'd4);
            update(pc_a, rand_info(), 1'b0, 1'b0);
            update(pc_b, rand_info(), 1'b0, 1'b0);
            update(pc_a, rand_info(), 1'b1, 1'b0);
            lookup(pc_a);
            lookup(pc_b);
            report("update on hit");

            set_asid(9'h005);
            pc_a = rand_pc(6'd40, 3'd1);
            update(pc_a, rand_info(), 1'b0, 1'b0);
            lookup(pc_a);
            set_asid(9'h00a);
            lookup(pc_a);
            set_asid(9'h005);
            lookup(pc_a);
            report("asid switch");
        end

        $display("%0d tests run, %0d assertion errors", test_num, i_btb.u_props.fail_count);
        if (i_btb.u_props.fail_count == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
